// File: sources.f
rtl/md_op_pkg.sv
rtl/md_state_pkg.sv
rtl/md_ctrl.sv
rtl/md_adder_path.sv
rtl/md_datapath.sv
rtl/multdiv_top.sv
verification/multdiv_checker.sv
verification/multdiv_tb.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= multdiv_tb
FILELIST  ?= sources.f
BUILD_DIR ?= build
LOG       ?= $(BUILD_DIR)/sim.log
VFLAGS    ?= --binary --timing --assert -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM)

$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@if grep -q "Test failed" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "Test completed successfully" $(LOG) || (echo "simulation did not finish"; exit 1)

clean:
	rm -rf $(BUILD_DIR)

// File: verification/multdiv_tb.sv
module multdiv_tb import md_op_pkg::*; ();

	localparam int DATA_WIDTH = 32;
	localparam int CLK_PERIOD = 100;
	localparam int DRIVE_DELAY = 10;
	localparam int RESET_CYCLES = 8;
	localparam int NUM_CORNER = 2 * 10 * 25; // two timing modes, ten op and mode pairs.
	localparam int NUM_RANDOM = 200;
	localparam int unsigned TIMEOUT_CYCLES =
		(NUM_CORNER + NUM_RANDOM) * (DATA_WIDTH + 4 + 4 + 2) + RESET_CYCLES + 20;

	logic clk_i = 1'b0;
	logic rst_ni;
	logic req_i;
	md_op_e operator_i;
	md_sign_t signed_mode_i;
	logic [DATA_WIDTH-1:0] op_a_i;
	logic [DATA_WIDTH-1:0] op_b_i;
	logic data_ind_timing_i;
	logic ready_i;
	logic [DATA_WIDTH-1:0] result_o;
	logic valid_o;
	integer seed;
	int unsigned cycles = 0;
	int unsigned ops_issued;
	int unsigned tests;
	int unsigned errors;
	logic [DATA_WIDTH-1:0] corners [5];

	always #(CLK_PERIOD / 2) clk_i = ~clk_i;

	multdiv_top #(
		.DATA_WIDTH(DATA_WIDTH)
	) uut (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.req_i            (req_i),
		.operator_i       (operator_i),
		.signed_mode_i    (signed_mode_i),
		.op_a_i           (op_a_i),
		.op_b_i           (op_b_i),
		.data_ind_timing_i(data_ind_timing_i),
		.ready_i          (ready_i),
		.result_o         (result_o),
		.valid_o          (valid_o)
	);

	multdiv_checker #(
		.DATA_WIDTH(DATA_WIDTH)
	) u_checker (
		.clk_i            (clk_i),
		.rst_ni           (rst_ni),
		.req_i            (req_i),
		.operator_i       (operator_i),
		.signed_mode_i    (signed_mode_i),
		.op_a_i           (op_a_i),
		.op_b_i           (op_b_i),
		.data_ind_timing_i(data_ind_timing_i),
		.ready_i          (ready_i),
		.result_i         (result_o),
		.valid_i          (valid_o),
		.tests_o          (tests),
		.errors_o         (errors)
	);

	function automatic int unsigned rand_below(input int unsigned n);
		return {$random(seed)} % n;
	endfunction

	// called just after an edge; returns just after the accepting edge.
	task automatic run_op(input md_op_e op, input md_sign_t mode, input logic [DATA_WIDTH-1:0] a,
			input logic [DATA_WIDTH-1:0] b, input logic dit);
		int unsigned hold;
		bit done;
		hold = rand_below(5); // back-pressure cycles once valid_o is up.
		if (rand_below(2) == 0) begin
			req_i = 1'b0;
			@(posedge clk_i);
			#DRIVE_DELAY;
		end
		operator_i = op;
		signed_mode_i = mode;
		op_a_i = a;
		op_b_i = b;
		data_ind_timing_i = dit;
		req_i = 1'b1;
		ready_i = (hold == 0);
		done = 1'b0;
		while (!done) begin
			@(posedge clk_i);
			if (valid_o && ready_i) begin
				done = 1'b1;
			end else begin
				#DRIVE_DELAY;
				if (valid_o && hold > 0) begin
					hold--;
				end
				ready_i = (hold == 0);
			end
		end
		#DRIVE_DELAY;
		ops_issued++;
	endtask

	initial begin
		int unsigned r;
		md_op_e op;
		md_sign_t mode;
		logic [DATA_WIDTH-1:0] a;
		logic [DATA_WIDTH-1:0] b;
		seed = 69;
		ops_issued = 0;
		rst_ni = 1'b0;
		req_i = 1'b0;
		operator_i = MD_OP_MULL;
		signed_mode_i = '0;
		op_a_i = '0;
		op_b_i = '0;
		data_ind_timing_i = 1'b0;
		ready_i = 1'b0;
		corners[0] = '0;
		corners[1] = {{(DATA_WIDTH-1){1'b0}}, 1'b1};
		corners[2] = '1;
		corners[3] = {1'b1, {(DATA_WIDTH-1){1'b0}}};
		corners[4] = {1'b0, {(DATA_WIDTH-1){1'b1}}};
		repeat (RESET_CYCLES) @(posedge clk_i);
		#DRIVE_DELAY;
		rst_ni = 1'b1;
		for (int t = 0; t < 2; t++) begin
			for (int o = 0; o < 4; o++) begin
				for (int m = 0; m < 4; m++) begin
					if (o == 1 || m == 0 || m == 3) begin // mixed modes only for mulh.
						for (int i = 0; i < 25; i++) begin
							run_op(md_op_e'(o[1:0]), m[1:0], corners[i / 5], corners[i % 5], t[0]);
						end
					end
				end
			end
		end
		for (int i = 0; i < NUM_RANDOM; i++) begin
			r = rand_below(4);
			op = md_op_e'(r[1:0]);
			r = rand_below(4);
			mode = (op inside {MD_OP_DIV, MD_OP_REM}) ? {r[0], r[0]} : r[1:0];
			a = DATA_WIDTH'($random(seed));
			b = (rand_below(8) == 0) ? DATA_WIDTH'(rand_below(4)) : DATA_WIDTH'($random(seed));
			r = rand_below(2);
			run_op(op, mode, a, b, r[0]);
		end
		req_i = 1'b0;
		repeat (2) @(posedge clk_i);
		$display("tests %0d, passed %0d, failed %0d", tests, tests - errors, errors);
		if (tests != ops_issued) begin
			$display("%0d results accepted for %0d requests", tests, ops_issued);
		end
		if (errors == 0 && tests == ops_issued) begin
			$display("Test completed successfully");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

	always @(posedge clk_i) begin
		cycles++;
		if (cycles > TIMEOUT_CYCLES) begin
			$display("timeout after %0d cycles, the tests did not finish", cycles);
			$display("Test failed");
			$finish;
		end
	end

endmodule

// File: verification/multdiv_checker.sv
module multdiv_checker import md_op_pkg::*; #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  req_i,
	input  md_op_e                operator_i,
	input  md_sign_t              signed_mode_i,
	input  logic [DATA_WIDTH-1:0] op_a_i,
	input  logic [DATA_WIDTH-1:0] op_b_i,
	input  logic                  data_ind_timing_i,
	input  logic                  ready_i,
	input  logic [DATA_WIDTH-1:0] result_i,
	input  logic                  valid_i,
	output int unsigned           tests_o,
	output int unsigned           errors_o
);

	localparam int W = DATA_WIDTH;

	md_op_e op_q;
	md_sign_t mode_q;
	logic [W-1:0] a_q;
	logic [W-1:0] b_q;
	logic [W-1:0] held_result;
	logic [W-1:0] expected;
	logic dit_q;
	logic busy = 1'b0;
	logic seen_valid;
	logic held;
	logic test_bad;
	int unsigned latency;
	int unsigned limit;
	int unsigned tests = 0;
	int unsigned errors = 0;
	string name;

	function automatic logic [W-1:0] md_ref(input md_op_e op, input md_sign_t mode,
			input logic [W-1:0] a, input logic [W-1:0] b);
		logic neg_a;
		logic neg_b;
		logic [2*W-1:0] prod;
		logic [W-1:0] mag_a;
		logic [W-1:0] mag_b;
		logic [W-1:0] quot;
		logic [W-1:0] rem;
		neg_a = mode[MD_SIGN_A] & a[W-1];
		neg_b = mode[MD_SIGN_B] & b[W-1];
		prod = {{W{neg_a}}, a} * {{W{neg_b}}, b};
		mag_a = neg_a ? -a : a; // min value keeps its bits, so min / -1 gives min.
		mag_b = neg_b ? -b : b;
		if (b == '0) begin
			quot = '1;
			rem = a;
		end else begin
			quot = mag_a / mag_b;
			rem = mag_a % mag_b;
			quot = (neg_a ^ neg_b) ? -quot : quot;
			rem = neg_a ? -rem : rem; // remainder follows the dividend.
		end
		case (op)
			MD_OP_MULL: return prod[W-1:0];
			MD_OP_MULH: return prod[2*W-1:W];
			MD_OP_DIV: return quot;
			default: return rem;
		endcase
	endfunction

	always @(posedge clk_i) begin
		if (!rst_ni) begin
			busy = 1'b0;
		end else if (busy) begin
			latency++;
			if (held && !valid_i) begin
				$display("%s: valid_o dropped before the result was taken", name);
				test_bad = 1'b1;
			end else if (held && result_i !== held_result) begin
				$display("%s: result_o changed while ready_i was low", name);
				test_bad = 1'b1;
			end
			if (valid_i && !seen_valid) begin
				seen_valid = 1'b1;
				if (dit_q ? (latency != limit) : (latency > limit)) begin
					$display("%s: valid_o came after %0d cycles, limit %0d", name, latency, limit);
					test_bad = 1'b1;
				end
			end else if (!seen_valid && latency == limit + 1) begin
				$display("%s: no valid_o within %0d cycles", name, limit);
				test_bad = 1'b1;
			end
			held = valid_i & ~ready_i;
			held_result = result_i;
			if (valid_i && ready_i) begin
				busy = 1'b0;
				tests++;
				expected = md_ref(op_q, mode_q, a_q, b_q);
				if (result_i !== expected) begin
					$display("mismatch %s: expected %h, actual %h", name, expected, result_i);
					test_bad = 1'b1;
				end else begin
					$display("%s %s", test_bad ? "fail" : "pass", name);
				end
				if (test_bad) begin
					errors++;
				end
			end
		end else if (req_i) begin
			busy = 1'b1; // request seen in idle.
			op_q = operator_i;
			mode_q = signed_mode_i;
			a_q = op_a_i;
			b_q = op_b_i;
			dit_q = data_ind_timing_i;
			latency = 0;
			seen_valid = 1'b0;
			held = 1'b0;
			test_bad = 1'b0;
			limit = (operator_i inside {MD_OP_MULL, MD_OP_MULH}) ? W : W + 4;
			name = $sformatf("%s #%0d mode %b a %h b %h dit %b", operator_i.name(), tests + 1,
				signed_mode_i, op_a_i, op_b_i, data_ind_timing_i);
		end
	end

	assign tests_o = tests;
	assign errors_o = errors;

endmodule

// File: rtl/multdiv_top.sv
module multdiv_top import md_op_pkg::*, md_state_pkg::*; #(
	parameter int DATA_WIDTH = 32
) (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  req_i,
	input  md_op_e                operator_i,
	input  md_sign_t              signed_mode_i,
	input  logic [DATA_WIDTH-1:0] op_a_i,
	input  logic [DATA_WIDTH-1:0] op_b_i,
	input  logic                  data_ind_timing_i,
	input  logic                  ready_i,
	output logic [DATA_WIDTH-1:0] result_o,
	output logic                  valid_o
);

	localparam int CNT_W = $clog2(DATA_WIDTH);

	md_state_e state;
	logic [CNT_W-1:0] count;
	logic reg_en;
	logic [DATA_WIDTH:0] accum;
	logic [DATA_WIDTH:0] a_shift;
	logic [DATA_WIDTH:0] b_shift;
	logic [DATA_WIDTH+1:0] adder_sum;
	logic b_shift_next_zero;
	logic op_b_zero;
	logic ge_flag;

	md_ctrl #(
		.DATA_WIDTH(DATA_WIDTH)
	) u_ctrl (
		.clk_i              (clk_i),
		.rst_ni             (rst_ni),
		.req_i              (req_i),
		.data_ind_timing_i  (data_ind_timing_i),
		.ready_i            (ready_i),
		.operator_i         (operator_i),
		.op_b_zero_i        (op_b_zero),
		.b_shift_next_zero_i(b_shift_next_zero),
		.state_o            (state),
		.count_o            (count),
		.reg_en_o           (reg_en),
		.valid_o            (valid_o)
	);

	md_adder_path #(
		.DATA_WIDTH(DATA_WIDTH)
	) u_adder_path (
		.operator_i (operator_i),
		.state_i    (state),
		.op_a_i     (op_a_i),
		.op_b_i     (op_b_i),
		.accum_i    (accum),
		.a_shift_i  (a_shift),
		.b_shift_i  (b_shift),
		.sum_o      (adder_sum),
		.op_b_zero_o(op_b_zero),
		.ge_o       (ge_flag)
	);

	md_datapath #(
		.DATA_WIDTH(DATA_WIDTH)
	) u_datapath (
		.clk_i              (clk_i),
		.rst_ni             (rst_ni),
		.reg_en_i           (reg_en),
		.operator_i         (operator_i),
		.signed_mode_i      (signed_mode_i),
		.state_i            (state),
		.count_i            (count),
		.op_a_i             (op_a_i),
		.op_b_i             (op_b_i),
		.sum_i              (adder_sum),
		.op_b_zero_i        (op_b_zero),
		.ge_i               (ge_flag),
		.accum_o            (accum),
		.a_shift_o          (a_shift),
		.b_shift_o          (b_shift),
		.b_shift_next_zero_o(b_shift_next_zero),
		.result_o           (result_o)
	);

endmodule

// File: rtl/md_datapath.sv
module md_datapath import md_op_pkg::*, md_state_pkg::*; #(
	parameter int DATA_WIDTH = 32,
	localparam int CNT_W = $clog2(DATA_WIDTH)
) (
	input  logic                  clk_i,
	input  logic                  rst_ni,
	input  logic                  reg_en_i,
	input  md_op_e                operator_i,
	input  md_sign_t              signed_mode_i,
	input  md_state_e             state_i,
	input  logic [CNT_W-1:0]      count_i,
	input  logic [DATA_WIDTH-1:0] op_a_i,
	input  logic [DATA_WIDTH-1:0] op_b_i,
	input  logic [DATA_WIDTH+1:0] sum_i,
	input  logic                  op_b_zero_i,
	input  logic                  ge_i,
	output logic [DATA_WIDTH:0]   accum_o,
	output logic [DATA_WIDTH:0]   a_shift_o,
	output logic [DATA_WIDTH:0]   b_shift_o,
	output logic                  b_shift_next_zero_o,
	output logic [DATA_WIDTH-1:0] result_o
);

	localparam int W = DATA_WIDTH;

	logic [W:0] accum_q;
	logic [W:0] accum_d;
	logic [W:0] a_shift_q;
	logic [W:0] a_shift_d;
	logic [W:0] b_shift_q;
	logic [W:0] b_shift_d;
	logic [W-1:0] numer_q;
	logic [W-1:0] numer_d;
	logic div_by_zero_q;
	logic div_by_zero_d;
	logic sign_a;
	logic sign_b;
	logic [W:0] op_a_ext;
	logic [W:0] op_b_ext;
	logic [W:0] res_l;
	logic [W:0] res_h;
	logic [W-1:0] adder_res;
	logic [CNT_W-1:0] count_next;
	logic [W:0] one_shift;
	logic [W-1:0] next_rem;
	logic [W:0] next_quot;
	logic div_change_sign;
	logic rem_change_sign;

	assign sign_a = op_a_i[W-1] & signed_mode_i[MD_SIGN_A];
	assign sign_b = op_b_i[W-1] & signed_mode_i[MD_SIGN_B];
	assign op_a_ext = {sign_a, op_a_i};
	assign op_b_ext = {sign_b, op_b_i};

	assign res_l = sum_i[W:0];
	assign res_h = sum_i[W+1:1]; // sum shifted right for mulh.
	assign adder_res = sum_i[W:1];

	assign count_next = count_i - 1'b1;
	assign one_shift = {{W{1'b0}}, 1'b1} << count_i;
	assign next_rem = ge_i ? res_h[W-1:0] : accum_q[W-1:0];
	assign next_quot = ge_i ? (a_shift_q | one_shift) : a_shift_q;
	assign div_change_sign = (sign_a ^ sign_b) & ~div_by_zero_q;
	assign rem_change_sign = sign_a;

	always_comb begin
		accum_d = accum_q;
		a_shift_d = a_shift_q;
		b_shift_d = b_shift_q;
		numer_d = numer_q;
		div_by_zero_d = div_by_zero_q;
		case (state_i)
			MD_IDLE: begin
				case (operator_i)
					MD_OP_MULL: begin
						a_shift_d = op_a_ext << 1;
						accum_d = {~(op_a_ext[W] & op_b_i[0]), op_a_ext[W-1:0] & {W{op_b_i[0]}}};
						b_shift_d = op_b_ext >> 1;
					end
					MD_OP_MULH: begin
						a_shift_d = op_a_ext;
						accum_d = {1'b1, ~(op_a_ext[W] & op_b_i[0]),
							op_a_ext[W-1:1] & {(W-1){op_b_i[0]}}};
						b_shift_d = op_b_ext >> 1;
					end
					MD_OP_DIV: begin
						accum_d = '1; // quotient for a zero divisor.
						div_by_zero_d = op_b_zero_i;
					end
					MD_OP_REM: begin
						accum_d = op_a_ext; // remainder for a zero divisor.
						div_by_zero_d = op_b_zero_i;
					end
				endcase
			end
			MD_ABS_A: begin
				a_shift_d = '0;
				numer_d = sign_a ? adder_res : op_a_i;
			end
			MD_ABS_B: begin
				accum_d = {{W{1'b0}}, numer_q[W-1]};
				b_shift_d = sign_b ? {1'b0, adder_res} : {1'b0, op_b_i};
			end
			MD_COMP: begin
				case (operator_i)
					MD_OP_MULL: begin
						accum_d = res_l;
						a_shift_d = a_shift_q << 1;
						b_shift_d = b_shift_q >> 1;
					end
					MD_OP_MULH: begin
						accum_d = res_h;
						b_shift_d = b_shift_q >> 1;
					end
					default: begin
						accum_d = {next_rem, numer_q[count_next]}; // bring down next bit.
						a_shift_d = next_quot;
					end
				endcase
			end
			MD_LAST: begin
				case (operator_i)
					MD_OP_DIV: accum_d = next_quot;
					MD_OP_REM: accum_d = {1'b0, next_rem};
					default: accum_d = res_l;
				endcase
			end
			MD_CHANGE_SIGN: begin
				if ((operator_i == MD_OP_DIV && div_change_sign) ||
						(operator_i == MD_OP_REM && rem_change_sign)) begin
					accum_d = {1'b0, adder_res};
				end
			end
			default: ;
		endcase
	end

	assign b_shift_next_zero_o = (b_shift_d == '0);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			a_shift_q <= '0;
			b_shift_q <= '0;
			div_by_zero_q <= 1'b0;
		end else if (reg_en_i) begin
			a_shift_q <= a_shift_d;
			b_shift_q <= b_shift_d;
			div_by_zero_q <= div_by_zero_d;
		end
	end

	always_ff @(posedge clk_i) begin
		if (reg_en_i) begin
			accum_q <= accum_d;
			numer_q <= numer_d;
		end
	end

	assign accum_o = accum_q;
	assign a_shift_o = a_shift_q;
	assign b_shift_o = b_shift_q;
	assign result_o = (operator_i inside {MD_OP_DIV, MD_OP_REM}) ? accum_q[W-1:0] : res_l[W-1:0];

	// numerator is indexed by count - 1, so the controller must leave comp before zero.
	count_no_wrap: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state_i == MD_COMP) |-> (count_i != '0));

endmodule

// File: rtl/md_adder_path.sv
module md_adder_path import md_op_pkg::*, md_state_pkg::*; #(
	parameter int DATA_WIDTH = 32
) (
	input  md_op_e                operator_i,
	input  md_state_e             state_i,
	input  logic [DATA_WIDTH-1:0] op_a_i,
	input  logic [DATA_WIDTH-1:0] op_b_i,
	input  logic [DATA_WIDTH:0]   accum_i,
	input  logic [DATA_WIDTH:0]   a_shift_i,
	input  logic [DATA_WIDTH:0]   b_shift_i,
	output logic [DATA_WIDTH+1:0] sum_o,
	output logic                  op_b_zero_o,
	output logic                  ge_o
);

	localparam int W = DATA_WIDTH;

	logic [W:0] add_a;
	logic [W:0] add_b;
	logic [W-1:0] b_bit;
	logic [W:0] pp;
	logic [W:0] last_pp;

	assign b_bit = {W{b_shift_i[0]}};
	// baugh-wooley partial products.
	assign pp = {~(a_shift_i[W] & b_shift_i[0]), a_shift_i[W-1:0] & b_bit};
	assign last_pp = {a_shift_i[W] & b_shift_i[0], ~(a_shift_i[W-1:0] & b_bit)};

	// for subtraction the operands carry a trailing one, so sum_o[W:1] is a - b.
	always_comb begin
		add_a = {accum_i[W-1:0], 1'b1};
		add_b = {~b_shift_i[W-1:0], 1'b1};
		case (operator_i)
			MD_OP_MULL: begin
				add_a = accum_i;
				add_b = pp;
			end
			MD_OP_MULH: begin
				add_a = accum_i;
				add_b = (state_i == MD_LAST) ? last_pp : pp;
			end
			default: begin
				case (state_i)
					MD_ABS_A: begin
						add_a = {{W{1'b0}}, 1'b1};
						add_b = {~op_a_i, 1'b1};
					end
					MD_ABS_B: begin
						add_a = {{W{1'b0}}, 1'b1};
						add_b = {~op_b_i, 1'b1};
					end
					MD_CHANGE_SIGN: begin
						add_a = {{W{1'b0}}, 1'b1};
						add_b = {~accum_i[W-1:0], 1'b1};
					end
					default: begin
						add_a = {accum_i[W-1:0], 1'b1}; // trial subtract.
						add_b = {~b_shift_i[W-1:0], 1'b1};
					end
				endcase
			end
		endcase
	end

	assign sum_o = {1'b0, add_a} + {1'b0, add_b};

	assign op_b_zero_o = (op_b_i == '0);
	// partial remainder against divisor.
	assign ge_o = (accum_i[W-1] == b_shift_i[W-1]) ? ~sum_o[W] : accum_i[W-1];

endmodule

// File: rtl/md_ctrl.sv
module md_ctrl import md_op_pkg::*, md_state_pkg::*; #(
	parameter int DATA_WIDTH = 32,
	localparam int CNT_W = $clog2(DATA_WIDTH)
) (
	input  logic             clk_i,
	input  logic             rst_ni,
	input  logic             req_i,
	input  logic             data_ind_timing_i,
	input  logic             ready_i,
	input  md_op_e           operator_i,
	input  logic             op_b_zero_i,
	input  logic             b_shift_next_zero_i,
	output md_state_e        state_o,
	output logic [CNT_W-1:0] count_o,
	output logic             reg_en_o,
	output logic             valid_o
);

	md_state_e state_q;
	md_state_e state_d;
	logic [CNT_W-1:0] count_q;
	logic [CNT_W-1:0] count_d;
	logic is_mult;
	logic last_step;
	logic mull_done;

	assign is_mult = (operator_i == MD_OP_MULL) | (operator_i == MD_OP_MULH);
	assign last_step = (count_q == CNT_W'(1));
	// remaining multiplier bits all zero.
	assign mull_done = (operator_i == MD_OP_MULL) & ~data_ind_timing_i & b_shift_next_zero_i;

	always_comb begin
		state_d = state_q;
		count_d = count_q;
		case (state_q)
			MD_IDLE: begin
				count_d = CNT_W'(DATA_WIDTH - 1);
				case (operator_i)
					MD_OP_MULL: begin
						state_d = mull_done ? MD_LAST : MD_COMP;
					end
					MD_OP_MULH: begin
						state_d = MD_COMP;
					end
					default: begin
						// zero divisor needs no iterations.
						state_d = (!data_ind_timing_i && op_b_zero_i) ? MD_FINISH : MD_ABS_A;
					end
				endcase
			end
			MD_ABS_A: begin
				state_d = MD_ABS_B;
			end
			MD_ABS_B: begin
				state_d = MD_COMP;
			end
			MD_COMP: begin
				count_d = count_q - 1'b1;
				if (last_step || mull_done) begin
					state_d = MD_LAST;
				end
			end
			MD_LAST: begin
				state_d = is_mult ? MD_IDLE : MD_CHANGE_SIGN;
			end
			MD_CHANGE_SIGN: begin
				state_d = MD_FINISH;
			end
			MD_FINISH: begin
				state_d = MD_IDLE;
			end
			default: begin
				state_d = MD_IDLE;
			end
		endcase
	end

	// result waits in last or finish until taken.
	assign valid_o = (state_q == MD_FINISH) | ((state_q == MD_LAST) & is_mult);
	assign reg_en_o = req_i & ~(valid_o & ~ready_i);

	always_ff @(posedge clk_i or negedge rst_ni) begin
		if (!rst_ni) begin
			state_q <= MD_IDLE;
			count_q <= '0;
		end else if (reg_en_o) begin
			state_q <= state_d;
			count_q <= count_d;
		end
	end

	assign state_o = state_q;
	assign count_o = count_q;

	// the datapath decodes the operator in every state of a run.
	operator_stable: assert property (@(posedge clk_i) disable iff (!rst_ni)
		(state_q != MD_IDLE) |-> $stable(operator_i));

endmodule

// File: rtl/md_state_pkg.sv
package md_state_pkg;

	// sequence of the iterative unit.
	typedef enum logic [2:0] {
		MD_IDLE        = 3'd0,
		MD_ABS_A       = 3'd1, // dividend magnitude.
		MD_ABS_B       = 3'd2, // divisor magnitude.
		MD_COMP        = 3'd3, // one bit per cycle.
		MD_LAST        = 3'd4,
		MD_CHANGE_SIGN = 3'd5,
		MD_FINISH      = 3'd6
	} md_state_e;

endpackage

// File: rtl/md_op_pkg.sv
package md_op_pkg;

	// operator codes as presented at the unit boundary.
	typedef enum logic [1:0] {
		MD_OP_MULL = 2'd0, // low word of the product.
		MD_OP_MULH = 2'd1, // high word.
		MD_OP_DIV  = 2'd2,
		MD_OP_REM  = 2'd3
	} md_op_e;

	// per-operand signedness of mulh, div and rem.
	typedef logic [1:0] md_sign_t;

	localparam int unsigned MD_SIGN_A = 0; // bit of md_sign_t for operand a.
	localparam int unsigned MD_SIGN_B = 1; // bit for operand b.

endpackage
